// File: hdl/event_buffer_pkg.sv
package event_buffer_pkg;

    // sample format of one channel
    localparam int SAMPLE_BITS = 12;
    localparam int WORD_SAMPLES = 6;

    // six samples are packed into one memory word
    localparam int MEM_WORD_BITS = SAMPLE_BITS * WORD_SAMPLES;

    // readout requests are only taken at one point of this cycle
    localparam int NUM_PHASES = 4;

    // defaults for the top-level parameters
    localparam int DEFAULT_NCHAN = 4;
    localparam int DEFAULT_ADDR_BITS = 8;
    localparam int DEFAULT_READ_LEN = 12;
    localparam int DEFAULT_READOUT_PHASE = 0;

    typedef logic [MEM_WORD_BITS-1:0] mem_word_t;

    typedef logic [$clog2(NUM_PHASES)-1:0] phase_t;

    typedef enum logic {
        ST_IDLE,
        ST_READING
    } readout_state_t;

endpackage

// File: hdl/readout_fsm.sv
module readout_fsm #(
    parameter int ADDR_BITS = event_buffer_pkg::DEFAULT_ADDR_BITS,
    parameter int READOUT_PHASE = event_buffer_pkg::DEFAULT_READOUT_PHASE
) (
    input  logic                 memclk,
    input  logic                 write_reset,
    input  logic                 sync_i,
    input  logic [ADDR_BITS-1:0] req_addr_i,
    input  logic                 req_valid_i,
    input  logic                 last_i,
    output logic                 req_ready_o,
    output logic                 start_o,
    output logic [ADDR_BITS-1:0] start_addr_o
);
    import event_buffer_pkg::*;

    phase_t         phase_q;
    readout_state_t state_q;
    logic           accept;

    // ready toggles with the phase while idle, low for the whole readout
    assign req_ready_o = (state_q == ST_IDLE) && (phase_q == phase_t'(READOUT_PHASE));
    assign accept = req_valid_i && req_ready_o;

    // sync marks phase 0, so the count after it is 1
    always_ff @(posedge memclk) begin
        if (write_reset) begin
            phase_q <= '0;
        end else if (sync_i) begin
            phase_q <= phase_t'(1);
        end else if (phase_q == phase_t'(NUM_PHASES - 1)) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    always_ff @(posedge memclk) begin
        if (write_reset) begin
            state_q <= ST_IDLE;
            start_o <= 1'b0;
        end else begin
            start_o <= accept;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_READING;
                    end
                end
                ST_READING: begin
                    // counter flags the final address
                    if (last_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // reads always begin on a 4-word boundary
    always_ff @(posedge memclk) begin
        if (accept) begin
            start_addr_o <= {req_addr_i[ADDR_BITS-1:2], 2'b00};
        end
    end

    // the counter flags its last address only inside a readout
    a_last_in_read: assert property (
        @(posedge memclk) disable iff (write_reset)
        last_i |-> (state_q == ST_READING)
    );

    // begin never lasts more than one cycle
    a_single_start: assert property (
        @(posedge memclk) disable iff (write_reset)
        start_o |=> !start_o
    );

endmodule

// File: hdl/read_counter.sv
module read_counter #(
    parameter int ADDR_BITS = event_buffer_pkg::DEFAULT_ADDR_BITS,
    parameter int READ_LEN = event_buffer_pkg::DEFAULT_READ_LEN
) (
    input  logic                 memclk,
    input  logic                 write_reset,
    input  logic                 start_i,
    input  logic [ADDR_BITS-1:0] start_addr_i,
    output logic                 rd_en_o,
    output logic [ADDR_BITS-1:0] rd_addr_o,
    output logic                 last_o
);
    localparam int CNT_BITS = $clog2(READ_LEN + 1);

    logic [CNT_BITS-1:0]  remain_q;
    logic [CNT_BITS-1:0]  remain_now;
    logic [ADDR_BITS-1:0] addr_q;

    // the start pulse counts as the first read cycle, so data lines up with begin
    assign remain_now = start_i ? CNT_BITS'(READ_LEN) : remain_q;
    assign rd_addr_o = start_i ? start_addr_i : addr_q;
    assign rd_en_o = (remain_now != '0);
    assign last_o = (remain_now == CNT_BITS'(1));

    // words still to read after the current one
    always_ff @(posedge memclk) begin
        if (write_reset) begin
            remain_q <= '0;
        end else if (rd_en_o) begin
            remain_q <= remain_now - 1'b1;
        end
    end

    // address wraps at the top of memory on its own
    always_ff @(posedge memclk) begin
        if (rd_en_o) begin
            addr_q <= rd_addr_o + 1'b1;
        end
    end

    // start address comes aligned from the FSM
    a_aligned_start: assert property (
        @(posedge memclk) disable iff (write_reset)
        start_i |-> (start_addr_i[1:0] == 2'b00)
    );

endmodule

// File: hdl/channel_store.sv
module channel_store #(
    parameter int ADDR_BITS = event_buffer_pkg::DEFAULT_ADDR_BITS
) (
    input  logic                        memclk,
    input  logic                        write_reset,
    input  event_buffer_pkg::mem_word_t wr_dat_i,
    input  logic                        rd_en_i,
    input  logic [ADDR_BITS-1:0]        rd_addr_i,
    output logic                        rd_en_o,
    output logic [ADDR_BITS-1:0]        rd_addr_o,
    output event_buffer_pkg::mem_word_t dat_o,
    output logic                        dat_valid_o
);
    import event_buffer_pkg::*;

    localparam int DEPTH = 2 ** ADDR_BITS;

    mem_word_t            mem [DEPTH];
    mem_word_t            rd_word_q;
    logic [ADDR_BITS-1:0] wr_ptr_q;

    // request pipeline, two stages like the memory cascade registers
    logic                 rd_en_d1;
    logic                 rd_en_d2;
    logic [ADDR_BITS-1:0] rd_addr_d1;
    logic [ADDR_BITS-1:0] rd_addr_d2;

    // free-running write pointer, first write after reset lands at 0
    always_ff @(posedge memclk) begin
        if (write_reset) begin
            wr_ptr_q <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    // every cycle writes one word
    // a read in the same cycle as a write to that address sees the older word
    always_ff @(posedge memclk) begin
        mem[wr_ptr_q] <= wr_dat_i;
        if (rd_en_i) begin
            rd_word_q <= mem[rd_addr_i];
        end
    end

    // output register after the memory read
    always_ff @(posedge memclk) begin
        if (rd_en_d1) begin
            dat_o <= rd_word_q;
        end
    end

    always_ff @(posedge memclk) begin
        if (write_reset) begin
            rd_en_d1 <= 1'b0;
            rd_en_d2 <= 1'b0;
        end else begin
            rd_en_d1 <= rd_en_i;
            rd_en_d2 <= rd_en_d1;
        end
    end

    always_ff @(posedge memclk) begin
        rd_addr_d1 <= rd_addr_i;
        rd_addr_d2 <= rd_addr_d1;
    end

    // data becomes valid just as the request moves on to the next channel
    assign dat_valid_o = rd_en_d2;
    assign rd_en_o = rd_en_d2;
    assign rd_addr_o = rd_addr_d2;

endmodule

// File: hdl/event_buffer.sv
module event_buffer #(
    parameter int NCHAN = event_buffer_pkg::DEFAULT_NCHAN,
    parameter int ADDR_BITS = event_buffer_pkg::DEFAULT_ADDR_BITS,
    parameter int READ_LEN = event_buffer_pkg::DEFAULT_READ_LEN,
    parameter int READOUT_PHASE = event_buffer_pkg::DEFAULT_READOUT_PHASE
) (
    input  logic                                    memclk,
    input  logic                                    write_reset,
    input  event_buffer_pkg::mem_word_t [NCHAN-1:0] dat_i,
    input  logic                                    sync_i,
    input  logic [ADDR_BITS-1:0]                    req_addr_i,
    input  logic                                    req_valid_i,
    output logic                                    req_ready_o,
    output logic                                    begin_o,
    output wire  event_buffer_pkg::mem_word_t [NCHAN-1:0] dat_o,
    output wire  [NCHAN-1:0]                        dat_valid_o
);
    logic                 start;
    logic [ADDR_BITS-1:0] start_addr;
    logic                 last;

    // read request chain, entry k feeds channel k
    wire [NCHAN:0]         chain_en;
    wire [ADDR_BITS-1:0]   chain_addr [NCHAN+1];

    readout_fsm #(
        .ADDR_BITS    (ADDR_BITS),
        .READOUT_PHASE(READOUT_PHASE)
    ) u_fsm (
        .memclk      (memclk),
        .write_reset (write_reset),
        .sync_i      (sync_i),
        .req_addr_i  (req_addr_i),
        .req_valid_i (req_valid_i),
        .last_i      (last),
        .req_ready_o (req_ready_o),
        .start_o     (start),
        .start_addr_o(start_addr)
    );

    assign begin_o = start;

    read_counter #(
        .ADDR_BITS(ADDR_BITS),
        .READ_LEN (READ_LEN)
    ) u_counter (
        .memclk      (memclk),
        .write_reset (write_reset),
        .start_i     (start),
        .start_addr_i(start_addr),
        .rd_en_o     (chain_en[0]),
        .rd_addr_o   (chain_addr[0]),
        .last_o      (last)
    );

    // each channel passes the request on two cycles later
    for (genvar k = 0; k < NCHAN; k++) begin : g_chan
        channel_store #(
            .ADDR_BITS(ADDR_BITS)
        ) u_store (
            .memclk     (memclk),
            .write_reset(write_reset),
            .wr_dat_i   (dat_i[k]),
            .rd_en_i    (chain_en[k]),
            .rd_addr_i  (chain_addr[k]),
            .rd_en_o    (chain_en[k+1]),
            .rd_addr_o  (chain_addr[k+1]),
            .dat_o      (dat_o[k]),
            .dat_valid_o(dat_valid_o[k])
        );
    end

endmodule

// File: testbench/tb_event_buffer.sv
module tb_event_buffer;
    import event_buffer_pkg::*;

    localparam int NCHAN = DEFAULT_NCHAN;
    localparam int ADDR_BITS = DEFAULT_ADDR_BITS;
    localparam int READ_LEN = DEFAULT_READ_LEN;
    localparam int READOUT_PHASE = DEFAULT_READOUT_PHASE;
    localparam int DEPTH = 2 ** ADDR_BITS;
    localparam int MAX_CYCLES = 3000;
    localparam int HIST_LEN = MAX_CYCLES + 16;

    logic                  memclk = 1'b0;
    logic                  write_reset;
    mem_word_t [NCHAN-1:0] dat_i;
    logic                  sync_i;
    logic [ADDR_BITS-1:0]  req_addr_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    logic                  begin_o;
    mem_word_t [NCHAN-1:0] dat_o;
    logic [NCHAN-1:0]      dat_valid_o;

    // reference model state, updated on every rising edge
    mem_word_t hist [NCHAN][HIST_LEN];
    int        wr_cnt = 0;
    int        mcycle = 0;
    phase_t    phase_m = '0;
    int        busy_m = 0;
    logic      begin_m = 1'b0;

    logic [31:0] lfsr_state = 32'hb0bd;
    int          drv_cnt = 0;
    int          timeout_cnt = 0;
    string       cur_test = "reset";

    event_buffer #(
        .NCHAN        (NCHAN),
        .ADDR_BITS    (ADDR_BITS),
        .READ_LEN     (READ_LEN),
        .READOUT_PHASE(READOUT_PHASE)
    ) DUT (
        .memclk     (memclk),
        .write_reset(write_reset),
        .dat_i      (dat_i),
        .sync_i     (sync_i),
        .req_addr_i (req_addr_i),
        .req_valid_i(req_valid_i),
        .req_ready_o(req_ready_o),
        .begin_o    (begin_o),
        .dat_o      (dat_o),
        .dat_valid_o(dat_valid_o)
    );

    always #50 memclk = ~memclk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic next_word(output mem_word_t w);
        for (int b = 0; b < MEM_WORD_BITS; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[b] = lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input logic [MEM_WORD_BITS-1:0] expected,
                               input logic [MEM_WORD_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic model_ready();
        return (busy_m == 0) && (phase_m == phase_t'(READOUT_PHASE));
    endfunction

    // word a read of addr returns when it happens at the edge carrying write index w
    function automatic mem_word_t expected_word(input int ch, input int addr, input int w);
        int n;
        n = w - 1 - (((w - 1 - addr) % DEPTH + DEPTH) % DEPTH);
        return hist[ch][n];
    endfunction

    // sample stream and sync pulses, all driven on the falling edge
    always @(negedge memclk) begin : drive_inputs
        mem_word_t w;
        drv_cnt++;
        sync_i = (drv_cnt % NUM_PHASES == 0);
        for (int k = 0; k < NCHAN; k++) begin
            next_word(w);
            dat_i[k] = w;
        end
    end

    always @(posedge memclk) begin : model_update
        logic ready_now;
        ready_now = model_ready();
        mcycle++;
        if (write_reset) begin
            phase_m = '0;
            busy_m = 0;
            begin_m = 1'b0;
            wr_cnt = 0;
        end else begin
            for (int k = 0; k < NCHAN; k++) begin
                hist[k][wr_cnt] = dat_i[k];
            end
            wr_cnt++;
            begin_m = ready_now && (req_valid_i === 1'b1);
            // busy until the edge that ends the last read cycle
            if (begin_m) begin
                busy_m = READ_LEN;
            end else if (busy_m > 0) begin
                busy_m--;
            end
            if (sync_i) begin
                phase_m = phase_t'(1);
            end else begin
                phase_m = phase_t'((phase_m + 1) % NUM_PHASES);
            end
        end
    end

    // ready and begin follow the model on every cycle
    always @(negedge memclk) begin
        if (mcycle > 0) begin
            check_value({cur_test, " ready"}, model_ready(), req_ready_o);
            check_value({cur_test, " begin"}, begin_m, begin_o);
        end
    end

    always @(posedge memclk) begin
        timeout_cnt = timeout_cnt + 1;
        if (timeout_cnt == MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // holds the request until it is taken, returns in the begin cycle
    task automatic issue_request(input logic [ADDR_BITS-1:0] addr, output int waited);
        waited = 0;
        req_addr_i = addr;
        req_valid_i = 1'b1;
        while (req_ready_o !== 1'b1) begin
            @(negedge memclk);
            waited++;
        end
        @(negedge memclk);
        req_valid_i = 1'b0;
        check_value({cur_test, " begin pulse"}, 1'b1, begin_o);
    endtask

    // called in the begin cycle, checks every channel's valid window and data
    task automatic watch_readout(input int base, input int wbase);
        int   j;
        logic want;
        for (int d = 0; d <= 2 * NCHAN + READ_LEN; d++) begin
            if (d > 0) begin
                check_value($sformatf("%s begin d=%0d", cur_test, d), 1'b0, begin_o);
            end
            for (int k = 0; k < NCHAN; k++) begin
                j = d - (2 + 2 * k);
                want = (j >= 0) && (j < READ_LEN);
                // earlier cycles can still hold the tail of a previous readout
                if (d > 2 * k) begin
                    check_value($sformatf("%s ch%0d valid d=%0d", cur_test, k, d),
                                want, dat_valid_o[k]);
                end
                if (want) begin
                    check_value($sformatf("%s ch%0d word %0d", cur_test, k, j),
                                expected_word(k, (base + j) % DEPTH, wbase + 2 * k + j),
                                dat_o[k]);
                end
            end
            @(negedge memclk);
        end
    endtask

    task automatic wait_memory_filled();
        while (wr_cnt < DEPTH) begin
            @(negedge memclk);
        end
    endtask

    task automatic test_reset_state();
        cur_test = "reset";
        for (int i = 0; i < 2 * NUM_PHASES; i++) begin
            check_value({cur_test, " begin"}, 1'b0, begin_o);
            check_value({cur_test, " valid"}, '0, dat_valid_o);
            check_value({cur_test, " ready"}, phase_m == phase_t'(READOUT_PHASE), req_ready_o);
            @(negedge memclk);
        end
    endtask

    task automatic test_single_readout();
        int addr;
        int waited;
        cur_test = "single";
        // half a memory away from the write pointer, low bits set
        addr = (((wr_cnt % DEPTH) + DEPTH / 2) % DEPTH & ~3) | 2;
        issue_request(ADDR_BITS'(addr), waited);
        watch_readout(addr & ~3, wr_cnt);
    endtask

    task automatic test_stagger();
        int addr;
        int base;
        int wbase;
        int waited;
        int first [NCHAN];
        int count [NCHAN];
        cur_test = "stagger";
        addr = (((wr_cnt % DEPTH) + DEPTH / 4) % DEPTH & ~3) | 1;
        base = addr & ~3;
        for (int k = 0; k < NCHAN; k++) begin
            first[k] = -1;
            count[k] = 0;
        end
        issue_request(ADDR_BITS'(addr), waited);
        wbase = wr_cnt;
        for (int d = 0; d <= 2 * NCHAN + READ_LEN; d++) begin
            for (int k = 0; k < NCHAN; k++) begin
                if (dat_valid_o[k] === 1'b1) begin
                    if (first[k] < 0) begin
                        first[k] = d;
                    end
                    check_value($sformatf("%s ch%0d word %0d", cur_test, k, count[k]),
                                expected_word(k, (base + count[k]) % DEPTH,
                                              wbase + 2 * k + count[k]),
                                dat_o[k]);
                    count[k]++;
                end
            end
            @(negedge memclk);
        end
        for (int k = 0; k < NCHAN; k++) begin
            check_value($sformatf("%s ch%0d first valid", cur_test, k), 2 + 2 * k, first[k]);
            check_value($sformatf("%s ch%0d valid count", cur_test, k), READ_LEN, count[k]);
        end
    endtask

    task automatic test_busy();
        int addr_a;
        int addr_b;
        int waited_a;
        int waited_b;
        int p0;
        int expect_wait;
        cur_test = "busy";
        addr_a = (((wr_cnt % DEPTH) + 64) % DEPTH & ~3) | 3;
        addr_b = (((wr_cnt % DEPTH) + 160) % DEPTH & ~3) | 1;
        issue_request(ADDR_BITS'(addr_a), waited_a);
        p0 = int'(phase_m);
        // second request goes up in the begin cycle of the first and stays up
        issue_request(ADDR_BITS'(addr_b), waited_b);
        expect_wait = READ_LEN;
        while ((p0 + expect_wait) % NUM_PHASES != READOUT_PHASE) begin
            expect_wait++;
        end
        check_value({cur_test, " cycles until ready"}, expect_wait, waited_b);
        watch_readout(addr_b & ~3, wr_cnt);
    endtask

    task automatic test_wrap();
        int addr;
        int waited;
        cur_test = "wrap";
        // aligned start 248, the last four words come from addresses 0 to 3
        addr = DEPTH - 5;
        issue_request(ADDR_BITS'(addr), waited);
        watch_readout(addr & ~3, wr_cnt);
    endtask

    initial begin
        write_reset = 1'b1;
        sync_i = 1'b0;
        req_addr_i = '0;
        req_valid_i = 1'b0;
        dat_i = '0;
        repeat (10) @(posedge memclk);
        @(negedge memclk);
        write_reset = 1'b0;
        test_reset_state();
        wait_memory_filled();
        test_single_readout();
        test_stagger();
        test_busy();
        test_wrap();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: all.f
hdl/event_buffer_pkg.sv
hdl/readout_fsm.sv
hdl/read_counter.sv
hdl/channel_store.sv
hdl/event_buffer.sv
testbench/tb_event_buffer.sv
